/* rtl/mdu_pkg.sv */
package mdu_pkg;

  // ------------------------------
  // widths and latencies
  // ------------------------------
  localparam int XLEN        = 32;             // operand width
  localparam int DIV_CNT_W   = $clog2(XLEN);   // divider iteration counter
  localparam int DIV_LATENCY = 33;             // start edge to valid edge, divides
  localparam int MUL_LATENCY = 2;              // start edge to valid edge, multiplies

  // ------------------------------
  // m-extension funct3 codes
  // ------------------------------
  typedef enum logic [2:0] {
    op_mul    = 3'd0,  // low word, signed x signed
    op_mulh   = 3'd1,  // high word, signed x signed
    op_mulhsu = 3'd2,  // high word, signed x unsigned
    op_mulhu  = 3'd3,  // high word, unsigned x unsigned
    op_div    = 3'd4,  // signed quotient
    op_divu   = 3'd5,  // unsigned quotient
    op_rem    = 3'd6,  // signed remainder
    op_remu   = 3'd7   // unsigned remainder
  } muldiv_funct3_t;

  // ------------------------------
  // request and response words
  // ------------------------------
  // bit 2 of op picks divider vs multiplier
  typedef struct packed {
    muldiv_funct3_t  op;   // operation
    logic [XLEN-1:0] rs1;  // first operand, dividend
    logic [XLEN-1:0] rs2;  // second operand, divisor
  } mdu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;  // product word, quotient or remainder
    muldiv_funct3_t  op;      // echo of the producing op
  } mdu_rsp_t;

endpackage

/* rtl/divider_unsigned.sv */
module divider_unsigned
  import mdu_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,        // one-cycle load strobe
  input  logic [XLEN-1:0] numerator_i,
  input  logic [XLEN-1:0] denominator_i,
  output logic [XLEN-1:0] quotient_o,
  output logic [XLEN-1:0] remainder_o,
  output logic            done_o          // one-cycle, results final
);

  // ------------------------------
  // state
  // ------------------------------
  logic [XLEN-1:0]      dividend_q;  // dividend bits out the top, quotient bits in the bottom
  logic [XLEN-1:0]      divisor_q;   // held for the whole run
  logic [XLEN-1:0]      rem_q;       // partial remainder
  logic [DIV_CNT_W-1:0] count_q;     // iteration index 0..XLEN-1
  logic                 running_q;
  logic                 done_q;

  logic [XLEN:0]        rem_shift;   // partial remainder with next dividend bit
  logic [XLEN:0]        trial;       // trial difference, msb is the sign
  logic                 q_bit;       // next quotient bit

  // ------------------------------
  // one restoring step
  // ------------------------------
  assign rem_shift = {rem_q, dividend_q[XLEN-1]};
  assign trial     = rem_shift - {1'b0, divisor_q};
  assign q_bit     = ~trial[XLEN];  // non-negative, so subtract

  // control, cleared by reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      running_q <= 1'b0;
      count_q   <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;  // pulse only
      if (start_i) begin
        running_q <= 1'b1;
        count_q   <= '0;
      end else if (running_q) begin
        count_q <= count_q + 1'b1;
        if (count_q == DIV_CNT_W'(XLEN - 1)) begin  // last bit this edge
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  // datapath, payload only
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      dividend_q <= numerator_i;
      divisor_q  <= denominator_i;
      rem_q      <= '0;
    end else if (running_q) begin
      rem_q      <= q_bit ? trial[XLEN-1:0] : rem_shift[XLEN-1:0];  // restore on negative
      dividend_q <= {dividend_q[XLEN-2:0], q_bit};
    end
  end

  // zero divisor falls out as all ones and the dividend
  assign quotient_o  = dividend_q;  // holds until next start
  assign remainder_o = rem_q;
  assign done_o      = done_q;

endmodule

/* rtl/divider_signed.sv */
module divider_signed
  import mdu_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,
  input  muldiv_funct3_t  op_i,           // div, divu, rem or remu
  input  logic [XLEN-1:0] numerator_i,
  input  logic [XLEN-1:0] denominator_i,
  output logic [XLEN-1:0] quotient_o,
  output logic [XLEN-1:0] remainder_o,
  output logic            done_o
);

  logic            signed_op;    // div or rem on the inputs
  logic [XLEN-1:0] num_mag;      // operand fed to the unsigned core
  logic [XLEN-1:0] den_mag;
  logic [XLEN-1:0] quot_u;       // raw unsigned results
  logic [XLEN-1:0] rem_u;

  muldiv_funct3_t  op_q;         // op of the run in flight
  logic            neg_quot_q;   // signs differ, divisor non-zero
  logic            neg_rem_q;    // remainder follows the dividend

  // ------------------------------
  // pre-processing
  // ------------------------------
  assign signed_op = (op_i == op_div) || (op_i == op_rem);
  assign num_mag   = (signed_op && numerator_i[XLEN-1])   ? -numerator_i   : numerator_i;
  assign den_mag   = (signed_op && denominator_i[XLEN-1]) ? -denominator_i : denominator_i;

  // capture at start so inputs may move during the run
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q       <= op_i;
      neg_quot_q <= (numerator_i[XLEN-1] ^ denominator_i[XLEN-1])
                    && (denominator_i != '0);  // div by zero keeps all ones
      neg_rem_q  <= numerator_i[XLEN-1];
    end
  end

  divider_unsigned i_divider_unsigned (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (start_i),
    .numerator_i   (num_mag),
    .denominator_i (den_mag),
    .quotient_o    (quot_u),
    .remainder_o   (rem_u),
    .done_o        (done_o)      // no added latency
  );

  // ------------------------------
  // post-processing
  // ------------------------------
  always_comb begin
    case (op_q)
      op_div, op_rem: begin
        quotient_o  = neg_quot_q ? -quot_u : quot_u;  // round toward zero
        remainder_o = neg_rem_q  ? -rem_u  : rem_u;   // sign of dividend
      end
      default: begin  // divu, remu
        quotient_o  = quot_u;
        remainder_o = rem_u;
      end
    endcase
  end

endmodule

/* rtl/multiplier.sv */
module multiplier
  import mdu_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,
  input  muldiv_funct3_t  op_i,       // mul, mulh, mulhsu or mulhu
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] product_o,
  output logic            valid_o     // two edges after start
);

  logic                   a_signed;    // rs1 treated as signed
  logic                   b_signed;    // rs2 treated as signed
  logic [XLEN:0]          a_ext;       // 33-bit extended operands
  logic [XLEN:0]          b_ext;

  // stage one
  logic [XLEN:0]          a_q;
  logic [XLEN:0]          b_q;
  muldiv_funct3_t         op_s1_q;
  logic                   valid_s1_q;

  // stage two
  logic signed [2*XLEN+1:0] prod_d;    // full 66-bit signed product
  logic [2*XLEN+1:0]      prod_q;
  muldiv_funct3_t         op_s2_q;
  logic                   valid_s2_q;

  // ------------------------------
  // operand extension
  // ------------------------------
  assign a_signed = (op_i == op_mulh) || (op_i == op_mulhsu);
  assign b_signed = (op_i == op_mulh);
  assign a_ext    = {a_signed & a_i[XLEN-1], a_i};
  assign b_ext    = {b_signed & b_i[XLEN-1], b_i};

  assign prod_d = $signed(a_q) * $signed(b_q);  // one signed multiply covers all four ops

  // valid strobes, cleared by reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_s1_q <= 1'b0;
      valid_s2_q <= 1'b0;
    end else begin
      valid_s1_q <= start_i;
      valid_s2_q <= valid_s1_q;
    end
  end

  // payload pipeline
  always_ff @(posedge clk_i) begin
    a_q     <= a_ext;
    b_q     <= b_ext;
    op_s1_q <= op_i;
    prod_q  <= prod_d;
    op_s2_q <= op_s1_q;
  end

  // low word for mul, high word for the mulh family
  assign product_o = (op_s2_q == op_mul) ? prod_q[XLEN-1:0] : prod_q[2*XLEN-1:XLEN];
  assign valid_o   = valid_s2_q;

endmodule

/* rtl/mdu_top.sv */
module mdu_top
  import mdu_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     start_i,   // one-cycle strobe
  input  mdu_req_t req_i,     // sampled with start_i
  output logic     valid_o,   // one-cycle strobe
  output mdu_rsp_t rsp_o,     // meaningful with valid_o
  output logic     busy_o     // divide in flight
);

  logic            accept;       // start not blocked by busy
  logic            mul_start;
  logic            div_start;

  logic            busy_q;
  muldiv_funct3_t  div_op_q;     // echo for the divide response
  muldiv_funct3_t  mul_op_s1_q;  // echo for the multiply response
  muldiv_funct3_t  mul_op_s2_q;

  logic [XLEN-1:0] mul_product;
  logic            mul_valid;
  logic [XLEN-1:0] div_quot;
  logic [XLEN-1:0] div_rem;
  logic            div_done;
  muldiv_funct3_t  rsp_op;

  // ------------------------------
  // dispatch
  // ------------------------------
  assign accept    = start_i & ~busy_q;       // dropped while dividing
  assign div_start = accept &  req_i.op[2];   // codes 4..7
  assign mul_start = accept & ~req_i.op[2];   // codes 0..3

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else if (div_start) begin
      busy_q <= 1'b1;
    end else if (div_done) begin
      busy_q <= 1'b0;  // through the valid cycle inclusive
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_start) begin
      div_op_q <= req_i.op;
    end
    mul_op_s1_q <= req_i.op;     // tracks the multiplier stages
    mul_op_s2_q <= mul_op_s1_q;
  end

  multiplier i_multiplier (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (mul_start),
    .op_i      (req_i.op),
    .a_i       (req_i.rs1),
    .b_i       (req_i.rs2),
    .product_o (mul_product),
    .valid_o   (mul_valid)
  );

  divider_signed i_divider_signed (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (div_start),
    .op_i          (req_i.op),
    .numerator_i   (req_i.rs1),
    .denominator_i (req_i.rs2),
    .quotient_o    (div_quot),
    .remainder_o   (div_rem),
    .done_o        (div_done)
  );

  // ------------------------------
  // response
  // ------------------------------
  assign rsp_op = div_done ? div_op_q : mul_op_s2_q;  // never both valid

  always_comb begin
    rsp_o.op = rsp_op;
    case (rsp_op)
      op_div, op_divu: rsp_o.result = div_quot;
      op_rem, op_remu: rsp_o.result = div_rem;
      default:         rsp_o.result = mul_product;
    endcase
  end

  assign valid_o = mul_valid | div_done;
  assign busy_o  = busy_q;

endmodule

/* dv/mdu_clk_gen.sv */
module mdu_clk_gen (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD = 10ns;  // 20 ns period

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

/* dv/mdu_checker.sv */
module mdu_checker
  import mdu_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input logic     start_i,
  input mdu_req_t req_i,
  input logic     valid_i,   // dut valid_o
  input logic     busy_i     // dut busy_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic div_acc;  // divide start taken this edge
  logic mul_acc;  // multiply start taken this edge

  assign div_acc = start_i && !busy_i &&  req_i.op[2];
  assign mul_acc = start_i && !busy_i && !req_i.op[2];

  // ------------------------------
  // handshake properties
  // ------------------------------
  quiet_after_reset: assert property (@(posedge clk_i) reset_i |=> !valid_i && !busy_i)
    else $error("valid_o or busy_o high after a reset edge");

  div_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    div_acc |-> ##DIV_LATENCY valid_i)
    else $error("divide valid missing at its latency");

  mul_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    mul_acc |-> ##MUL_LATENCY valid_i)
    else $error("multiply valid missing at its latency");

  // two valids in a row only from two multiplies in a row
  valid_pairs: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && $past(valid_i) |-> $past(mul_acc, MUL_LATENCY) && $past(mul_acc, MUL_LATENCY + 1))
    else $error("back to back valid without back to back starts");

endmodule

/* dv/mdu_tb.sv */
module mdu_tb
  import mdu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // about 200 divides at ~36 cycles, 190 multiplies and idle gaps, ~7800 cycles
  localparam int TIMEOUT_CYCLES = 12000;

  logic     clk;
  logic     reset;
  logic     start;
  mdu_req_t req;
  logic     valid;
  mdu_rsp_t rsp;
  logic     busy;

  int       edge_cnt;       // rising edges so far
  int       errors;
  int       tests_passed;
  int       tests_failed;

  mdu_rsp_t exp_q[$];       // expected responses, issue order
  int       exp_edge_q[$];  // edge where each is due
  string    exp_name_q[$];
  mdu_rsp_t got_q[$];       // responses seen at the outputs
  int       got_edge_q[$];

  mdu_clk_gen i_mdu_clk_gen (.clk_o(clk));

  mdu_top i_mdu_top (
    .clk_i   (clk),
    .reset_i (reset),
    .start_i (start),
    .req_i   (req),
    .valid_o (valid),
    .rsp_o   (rsp),
    .busy_o  (busy)
  );

  bind mdu_top mdu_checker i_mdu_checker (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start_i),
    .req_i   (req_i),
    .valid_i (valid_o),
    .busy_i  (busy_o)
  );

  // ------------------------------
  // monitor and watchdog
  // ------------------------------
  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
    if (edge_cnt >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", edge_cnt);
      $display("Errors found");
      $finish;
    end
  end

  always @(negedge clk) begin  // outputs settled mid cycle
    if (!reset && valid) begin
      got_q.push_back(rsp);
      got_edge_q.push_back(edge_cnt + 1);  // edge that samples it
    end
  end

  // RISC-V M rules, 64-bit math keeps most negative / -1 exact
  function automatic logic [31:0] expected_result(muldiv_funct3_t op, logic [31:0] a,
                                                  logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        p;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    p  = '1;  // quotient of a zero divisor
    case (op)
      op_mul, op_mulh: p = sa * sb;
      op_mulhsu:       p = sa * $signed({32'h0, b});
      op_mulhu:        p = {32'h0, a} * {32'h0, b};
      op_div:          if (b != 0) p = sa / sb;  // truncates toward zero
      op_divu:         if (b != 0) p = {32'h0, a} / {32'h0, b};
      op_rem:          p = (b != 0) ? sa % sb : sa;  // dividend sign
      default:         p = (b != 0) ? {32'h0, a % b} : {32'h0, a};
    endcase
    return (op == op_mul || op[2]) ? p[31:0] : p[63:32];
  endfunction

  task automatic compare_rsp(input string name, input mdu_rsp_t exp, input mdu_rsp_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h op %0d, actual %h op %0d", name, exp.result, exp.op,
               act.result, act.op);
      errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // ------------------------------
  // drive and collect
  // ------------------------------
  task automatic issue_req(input string name, input muldiv_funct3_t op, input logic [31:0] a,
                           input logic [31:0] b, input bit expect_rsp);
    mdu_rsp_t exp;
    @(posedge clk);
    start <= 1'b1;
    req   <= '{op: op, rs1: a, rs2: b};
    @(negedge clk);
    if (expect_rsp) begin
      exp.result = expected_result(op, a, b);
      exp.op     = op;
      exp_q.push_back(exp);
      exp_edge_q.push_back(edge_cnt + 1 + (op[2] ? DIV_LATENCY : MUL_LATENCY));  // next edge takes it
      exp_name_q.push_back(name);
    end
  endtask

  task automatic release_start();
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic collect_responses();
    int       waited;
    int       exp_edge;
    int       got_edge;
    string    name;
    mdu_rsp_t exp_rsp;
    mdu_rsp_t got_rsp;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < DIV_LATENCY + 8) begin
      @(posedge clk);
      waited++;
    end
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      name     = exp_name_q.pop_front();
      exp_rsp  = exp_q.pop_front();
      got_rsp  = got_q.pop_front();
      exp_edge = exp_edge_q.pop_front();
      got_edge = got_edge_q.pop_front();
      compare_rsp(name, exp_rsp, got_rsp);
      if (got_edge != exp_edge) begin
        $display("%s: response arrived at edge %0d, due at edge %0d", name, got_edge, exp_edge);
        errors++;
      end
    end
    if (exp_q.size() != 0 || got_q.size() != 0) begin
      $display("%0d responses never arrived, %0d arrived unasked", exp_q.size(), got_q.size());
      errors++;
    end
    exp_q.delete();
    exp_edge_q.delete();
    exp_name_q.delete();
    got_q.delete();
    got_edge_q.delete();
  endtask

  task automatic run_op(input string name, input muldiv_funct3_t op, input logic [31:0] a,
                        input logic [31:0] b);
    issue_req(name, op, a, b, 1'b1);
    release_start();
    collect_responses();
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      tests_passed++;
      $display("%-18s passed", name);
    end else begin
      tests_failed++;
      $display("%-18s failed, %0d errors", name, errors - err0);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic unsigned_divides();
    logic [31:0] vals[3] = '{32'h0, 32'h1, 32'hffff_ffff};
    logic [31:0] a;
    logic [31:0] b;
    int          err0;
    err0 = errors;
    foreach (vals[i]) begin
      foreach (vals[j]) begin
        run_op("divu edge", op_divu, vals[i], vals[j]);
        run_op("remu edge", op_remu, vals[i], vals[j]);
      end
    end
    repeat (40) begin
      a = $urandom;
      b = $urandom >> ($urandom % 32);  // spread of quotient sizes
      run_op("divu random", op_divu, a, b);
      run_op("remu random", op_remu, a, b);
    end
    report_test("unsigned divides", err0);
  endtask

  task automatic signed_divides();
    logic [31:0] a;
    logic [31:0] b;
    int          err0;
    err0 = errors;
    for (int s = 0; s < 4; s++) begin  // all four sign pairs
      a = s[0] ? -32'd7 : 32'd7;
      b = s[1] ? -32'd2 : 32'd2;
      run_op("div signs", op_div, a, b);
      run_op("rem signs", op_rem, a, b);
    end
    repeat (40) begin
      a = $urandom;
      b = $urandom >> ($urandom % 32);
      if ($urandom % 2) b = -b;
      run_op("div random", op_div, a, b);
      run_op("rem random", op_rem, a, b);
    end
    report_test("signed divides", err0);
  endtask

  task automatic divide_corners();
    muldiv_funct3_t div_ops[4] = '{op_div, op_divu, op_rem, op_remu};
    int             err0;
    err0 = errors;
    foreach (div_ops[i]) begin
      run_op("divide by zero", div_ops[i], 32'h1234_5678, 32'h0);
      run_op("divide by zero", div_ops[i], 32'h8765_4321, 32'h0);  // negative dividend
      run_op("signed overflow", div_ops[i], 32'h8000_0000, 32'hffff_ffff);
    end
    report_test("divide corners", err0);
  endtask

  task automatic multiply_stream();
    muldiv_funct3_t mul_ops[4] = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
    logic [31:0]    vals[5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    int             err0;
    err0 = errors;
    foreach (mul_ops[k]) begin  // one start per cycle, no gaps
      foreach (vals[i]) begin
        foreach (vals[j]) begin
          issue_req("multiply edge", mul_ops[k], vals[i], vals[j], 1'b1);
        end
      end
    end
    repeat (20) begin
      foreach (mul_ops[k]) begin
        issue_req("multiply random", mul_ops[k], $urandom, $urandom, 1'b1);
      end
    end
    release_start();
    collect_responses();
    report_test("multiply stream", err0);
  endtask

  task automatic busy_drop();
    int err0;
    err0 = errors;
    issue_req("divide under busy", op_div, 32'hfedc_ba98, 32'h0000_0123, 1'b1);
    release_start();
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_flag("busy while dividing", 1'b1, busy);
    issue_req("dropped divide", op_divu, 32'h100, 32'h3, 1'b0);
    issue_req("dropped multiply", op_mul, 32'h5, 32'h7, 1'b0);
    release_start();
    collect_responses();
    @(negedge clk);
    compare_flag("busy after valid", 1'b0, busy);
    repeat (40) @(posedge clk);
    collect_responses();  // any late valid from a dropped start
    report_test("start while busy", err0);
  endtask

  task automatic reset_mid_divide();
    int err0;
    err0 = errors;
    issue_req("aborted divide", op_div, 32'h7654_3210, 32'h0000_0011, 1'b0);
    release_start();
    repeat (10) @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    compare_flag("valid in reset", 1'b0, valid);
    compare_flag("busy in reset", 1'b0, busy);
    @(posedge clk);
    reset <= 1'b0;
    repeat (40) @(posedge clk);
    collect_responses();  // aborted run must stay silent
    run_op("divide after reset", op_div, 32'h7654_3210, 32'h0000_0011);
    report_test("reset mid divide", err0);
  endtask

  initial begin
    void'($urandom(32'h513));
    reset = 1'b1;
    start = 1'b0;
    req   = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    unsigned_divides();
    signed_divides();
    divide_corners();
    multiply_stream();
    busy_drop();
    reset_mid_divide();
    $display("tests passed: %0d, tests failed: %0d, failed checks: %0d", tests_passed,
             tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* project.f */
rtl/mdu_pkg.sv
rtl/divider_unsigned.sv
rtl/divider_signed.sv
rtl/multiplier.sv
rtl/mdu_top.sv
dv/mdu_clk_gen.sv
dv/mdu_checker.sv
dv/mdu_tb.sv

/* run.sh */
#!/bin/sh
# build the mdu testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module mdu_tb -f project.f -o mdu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/mdu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
